//--- include/draw_model.svh
/*
 * Reference model for the score panel testbench.
 * Include inside a module that imports draw_pkg.
 * Lanes from y 200, signs 24x64 at y 453, digit cells 24x20 on a 23 px pitch.
 */
`ifndef DRAW_MODEL_SVH
`define DRAW_MODEL_SVH

// sprite ROM contents, a fixed scramble of the address
function automatic logic [15:0] rom_word(input sprite_addr_t a);
	logic [15:0] w;
	w = {1'b0, a} * 16'd40503;
	return w ^ {a[6:0], a[14:6]} ^ 16'h3c5a;
endfunction

// column-major offset inside a box, -1 when outside
function automatic int box_offset(input int x, input int y, input int x0, input int y0,
		input int w, input int h);
	if (x < x0 || x >= x0 + w || y < y0 || y >= y0 + h)
		return -1;
	return (x - x0) * h + (y - y0);
endfunction

// cnt[0] is perfect ... cnt[5] is combo
function automatic sprite_addr_t model_addr(input coord_t x, input coord_t y,
		input logic [3:0] keys, input bcd4_t [5:0] cnt, input grade_t grade);
	int stack_x [6] = '{396, 356, 316, 276, 236, 396};
	int stack_y [6] = '{527, 527, 527, 527, 527, 98};
	int sign_base [5] = '{4800, 6336, 7872, 9408, 10944};
	int xi;
	int yi;
	int g;
	int off;
	int lane;
	int res;
	xi = int'(x);
	yi = int'(y);
	g = int'(grade);
	res = -1;
	if (yi >= 200 && yi < 440) begin
		lane = (yi - 200) / 60;
		if (xi < 420)
			res = 0; // note area
		else
			res = (keys[lane] ? 19080 : 22680) + (xi - 420) * 60 + (yi - 200 - lane * 60);
	end
	for (int s = 0; s < 5; s++) begin
		off = box_offset(xi, yi, stack_x[s], 453, 24, 64);
		if (res < 0 && off >= 0)
			res = sign_base[s] + off;
	end
	if (res < 0) begin
		off = box_offset(xi, yi, 356, 123, 24, 64);
		if (off >= 0)
			res = (g >= 1 && g <= 5) ? sign_base[g - 1] + off : 0;
	end
	if (res < 0) begin
		for (int c = 0; c < 6; c++) begin
			for (int r = 0; r < 4; r++) begin
				off = box_offset(xi, yi, stack_x[c], stack_y[c] + r * 23, 24, 20);
				if (off >= 0)
					res = int'(cnt[c][(3 - r) * 4 +: 4]) * 480 + off;
			end
		end
	end
	if (res < 0)
		res = 0;
	return sprite_addr_t'(res); // 15-bit wrap
endfunction

`endif

//--- bench/draw_controller_tb.sv
/*
 * Testbench for the score panel draw controller.
 * Behavioural sprite ROM with one cycle of latency, LFSR stimulus, fixed seed.
 * Stops at the first mismatch.
 */
`timescale 1ns/1ps

module draw_controller_tb;
	import draw_pkg::*;

	`include "draw_model.svh"

	localparam int first_reqs = 6;
	localparam int frames = 24;
	localparam int reqs_per_frame = 16;
	localparam int total_reqs = first_reqs + frames * reqs_per_frame;
	localparam int timeout_cycles = 10 + total_reqs * 8 + frames * 8 + 100;

	logic CLK;
	logic RESET_L;
	logic sig_on;
	logic sig_done;
	logic [3:0] is_key_down;
	grade_t current_score;
	bcd4_t miss, bad, good, great, perfect, combo;
	logic vga_reset;
	channel_t vga_r, vga_g, vga_b;
	coord_t vga_x, vga_y;
	logic vga_request;
	sprite_addr_t ds_b_addr;
	logic [15:0] ds_b_data_out;
	logic ds_b_en;

	logic [31:0] lfsr_state;
	logic [15:0] rom_q;
	bcd4_t [5:0] snap_cnt; // model of the snapshot bank
	grade_t snap_grade;

	draw_controller UUT (.*);

	assign ds_b_data_out = rom_q;

	always #2 CLK = ~CLK;

	always @(posedge CLK) begin
		if (ds_b_en)
			rom_q <= rom_word(ds_b_addr);
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	task automatic check_addr(input sprite_addr_t got, input sprite_addr_t exp);
		if (got !== exp) begin
			$display("Error at %0t: ds_b_addr %0d for pixel (%0d,%0d), expected %0d",
				$time, got, vga_x, vga_y, exp);
			$display("FAIL: see errors above");
			$fatal(1, "address mismatch");
		end
	endtask

	task automatic check_rgb(input channel_t r, input channel_t g, input channel_t b,
			input channel_t er, input channel_t eg, input channel_t eb);
		if (r !== er || g !== eg || b !== eb) begin
			$display("Error at %0t: rgb %h/%h/%h, expected %h/%h/%h",
				$time, r, g, b, er, eg, eb);
			$display("FAIL: see errors above");
			$fatal(1, "colour mismatch");
		end
	endtask

	task automatic check_pulse(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
			$display("FAIL: see errors above");
			$fatal(1, "strobe mismatch");
		end
	endtask

	// aims at lanes, signs, digits or anywhere on screen
	task automatic pick_pixel(output coord_t x, output coord_t y);
		int kind;
		kind = int'(rand_bits(3));
		case (kind)
			0, 1: begin
				x = coord_t'(400 + int'(rand_bits(7)));
				y = coord_t'(195 + int'(rand_bits(8)) % 250);
			end
			2: begin
				x = coord_t'(230 + int'(rand_bits(8)) % 200);
				y = coord_t'(448 + int'(rand_bits(7)) % 74);
			end
			3: begin
				x = coord_t'(350 + int'(rand_bits(6)) % 36);
				y = coord_t'(118 + int'(rand_bits(7)) % 74);
			end
			4: begin
				x = coord_t'(230 + int'(rand_bits(8)) % 200);
				y = coord_t'(522 + int'(rand_bits(7)) % 100);
			end
			5: begin
				x = coord_t'(390 + int'(rand_bits(6)) % 36);
				y = coord_t'(93 + int'(rand_bits(7)) % 100);
			end
			default: begin
				x = coord_t'(int'(rand_bits(10)) % 640);
				y = coord_t'(int'(rand_bits(9)) % 480);
			end
		endcase
	endtask

	task automatic start_frame();
		bcd4_t [5:0] v;
		grade_t g;
		for (int i = 0; i < 6; i++)
			v[i] = bcd4_t'(rand_bits(16));
		g = grade_t'(4'(rand_bits(4)));
		@(posedge CLK);
		{combo, miss, bad, good, great, perfect} <= v;
		current_score <= g;
		sig_on <= 1'b1;
		snap_cnt = v;
		snap_grade = g;
		@(negedge CLK);
		check_pulse("sig_done", sig_done, 1'b0);
		@(posedge CLK);
		sig_on <= 1'b0;
		// live inputs move away from the snapshot
		{combo, miss, bad, good, great, perfect} <= {6{bcd4_t'(rand_bits(16))}};
		current_score <= grade_t'(4'(rand_bits(4)));
		@(negedge CLK);
		check_pulse("sig_done", sig_done, 1'b1);
		check_pulse("vga_reset", vga_reset, 1'b0);
		@(negedge CLK);
		check_pulse("sig_done", sig_done, 1'b0);
	endtask

	// first frame, no ROM access and black out
	task automatic blank_request();
		coord_t x, y;
		pick_pixel(x, y);
		@(posedge CLK);
		vga_x <= x;
		vga_y <= y;
		vga_request <= 1'b1;
		@(posedge CLK);
		vga_request <= 1'b0;
		repeat (4) begin
			@(negedge CLK);
			check_pulse("ds_b_en", ds_b_en, 1'b0);
		end
		check_rgb(vga_r, vga_g, vga_b, 4'h0, 4'h0, 4'h0);
	endtask

	task automatic fetch_request();
		coord_t x, y;
		logic [3:0] keys;
		sprite_addr_t exp_addr;
		logic [15:0] word;
		pick_pixel(x, y);
		keys = 4'(rand_bits(4));
		exp_addr = model_addr(x, y, keys, snap_cnt, snap_grade);
		word = rom_word(exp_addr);
		@(posedge CLK);
		vga_x <= x;
		vga_y <= y;
		is_key_down <= keys;
		vga_request <= 1'b1;
		@(negedge CLK);
		check_addr(ds_b_addr, exp_addr);
		@(posedge CLK);
		vga_request <= 1'b0;
		repeat (3) begin
			@(negedge CLK);
			check_pulse("ds_b_en", ds_b_en, 1'b1);
		end
		@(negedge CLK); // third edge after the sampled request
		check_pulse("ds_b_en", ds_b_en, 1'b0);
		check_rgb(vga_r, vga_g, vga_b, word[3:0], word[7:4], word[11:8]);
		repeat (int'(rand_bits(2))) @(posedge CLK);
	endtask

	initial begin
		#(timeout_cycles * 4);
		$display("timeout: the run did not finish within %0d clock cycles", timeout_cycles);
		$display("FAIL: see errors above");
		$fatal(1, "watchdog");
	end

	initial begin
		CLK = 1'b0;
		RESET_L = 1'b0;
		sig_on = 1'b0;
		is_key_down = '0;
		current_score = grade_none;
		{combo, miss, bad, good, great, perfect} = '0;
		vga_x = '0;
		vga_y = '0;
		vga_request = 1'b0;
		rom_q = '0;
		lfsr_state = 32'hcd1d_b8e7;
		snap_cnt = '0;
		snap_grade = grade_none;
		repeat (10) @(posedge CLK);
		RESET_L <= 1'b1;
		@(negedge CLK);
		check_pulse("vga_reset", vga_reset, 1'b1);
		check_pulse("sig_done", sig_done, 1'b0);
		check_pulse("ds_b_en", ds_b_en, 1'b0);
		check_rgb(vga_r, vga_g, vga_b, 4'h0, 4'h0, 4'h0);
		start_frame();
		repeat (first_reqs) blank_request();
		for (int f = 0; f < frames; f++) begin
			start_frame();
			repeat (reqs_per_frame) fetch_request();
		end
		$display("PASS: all tests");
		$finish;
	end

endmodule

//--- include/draw_cfg.svh
/*
 * Screen geometry and sprite ROM layout of the score panel.
 * Coordinates are sized to 10 bits and ROM addresses to 15 bits.
 * Sign sprites are stored column-major (x * height + y). Digit d starts at d * DIGIT_SIZE.
 */
`ifndef DRAW_CFG_SVH
`define DRAW_CFG_SVH

// lane rows, y 200 to 439
`define DRAW_LANE_TOP   10'd200
`define DRAW_LANE_H     10'd60
`define DRAW_LANE_CNT   4
`define DRAW_BUTTON_X   10'd420 // key indicator starts here

`define DRAW_SIGN_W     10'd24
`define DRAW_SIGN_H     10'd64

`define DRAW_DIGIT_W    10'd24
`define DRAW_DIGIT_H    10'd20
`define DRAW_DIGIT_GAP  10'd3
`define DRAW_DIGIT_SIZE 15'd480

`define DRAW_PERFECT_X  10'd396
`define DRAW_GREAT_X    10'd356
`define DRAW_GOOD_X     10'd316
`define DRAW_BAD_X      10'd276
`define DRAW_MISS_X     10'd236
`define DRAW_SIGN_Y     10'd453
`define DRAW_GRADE_X    10'd356
`define DRAW_GRADE_Y    10'd123
`define DRAW_COMBO_X    10'd396
`define DRAW_COMBO_Y    10'd98
// score stacks sit 10 px under the signs
`define DRAW_DIGIT_Y    (`DRAW_SIGN_Y + `DRAW_SIGN_H + 10'd10)

`define DRAW_PERFECT_BASE 15'd4800
`define DRAW_GREAT_BASE   15'd6336
`define DRAW_GOOD_BASE    15'd7872
`define DRAW_BAD_BASE     15'd9408
`define DRAW_MISS_BASE    15'd10944
`define DRAW_DOWN_BASE    15'd19080
`define DRAW_UP_BASE      15'd22680

`endif

//--- rtl/digit_mapper.sv
/*
 * BCD digit stacks of the six score counters.
 * Each stack is four cells of 24x20, 3 px apart, msd on top.
 * Digit values above 9 index past the digit sprites without any check.
 */
`timescale 1ns/1ps
`include "draw_cfg.svh"

module digit_mapper (
	input draw_pkg::coord_t vga_x,
	input draw_pkg::coord_t vga_y,
	input draw_pkg::bcd4_t snap_perfect,
	input draw_pkg::bcd4_t snap_great,
	input draw_pkg::bcd4_t snap_good,
	input draw_pkg::bcd4_t snap_bad,
	input draw_pkg::bcd4_t snap_miss,
	input draw_pkg::bcd4_t snap_combo,
	output logic digit_hit,
	output draw_pkg::sprite_addr_t digit_addr
);
	import draw_pkg::*;

	localparam int stack_cnt = 6;
	localparam coord_t pitch = `DRAW_DIGIT_H + `DRAW_DIGIT_GAP;
	localparam coord_t stack_x [stack_cnt] = '{`DRAW_PERFECT_X, `DRAW_GREAT_X,
		`DRAW_GOOD_X, `DRAW_BAD_X, `DRAW_MISS_X, `DRAW_COMBO_X};
	localparam coord_t stack_y [stack_cnt] = '{`DRAW_DIGIT_Y, `DRAW_DIGIT_Y,
		`DRAW_DIGIT_Y, `DRAW_DIGIT_Y, `DRAW_DIGIT_Y, `DRAW_COMBO_Y};

	bcd4_t [stack_cnt-1:0] counters; // index 0 is perfect

	assign counters = {snap_combo, snap_miss, snap_bad, snap_good, snap_great, snap_perfect};

	always_comb begin : digit_search
		coord_t row_y;
		logic [3:0] digit;
		digit_hit = 1'b0;
		digit_addr = '0;
		for (int c = 0; c < stack_cnt; c++) begin
			for (int r = 0; r < 4; r++) begin
				row_y = coord_t'(stack_y[c] + r * pitch);
				digit = counters[c][(3 - r) * 4 +: 4];
				if (vga_x >= stack_x[c] && vga_x < stack_x[c] + `DRAW_DIGIT_W
					&& vga_y >= row_y && vga_y < row_y + `DRAW_DIGIT_H) begin
					digit_hit = 1'b1; // later stacks win
					digit_addr = sprite_addr_t'(digit) * `DRAW_DIGIT_SIZE
						+ sprite_addr_t'(vga_x - stack_x[c]) * `DRAW_DIGIT_H
						+ sprite_addr_t'(vga_y - row_y);
				end
			end
		end
	end

endmodule

//--- rtl/draw_controller.sv
/*
 * Score panel draw controller, top level.
 * Counters and grade are sampled on sig_on and drawn from that snapshot.
 * Sprite ROM is external with one cycle of read latency.
 */
`timescale 1ns/1ps

module draw_controller (
	input logic CLK,
	input logic RESET_L,
	input logic sig_on,
	output logic sig_done,
	input logic [3:0] is_key_down,
	input draw_pkg::grade_t current_score,
	input draw_pkg::bcd4_t miss,
	input draw_pkg::bcd4_t bad,
	input draw_pkg::bcd4_t good,
	input draw_pkg::bcd4_t great,
	input draw_pkg::bcd4_t perfect,
	input draw_pkg::bcd4_t combo,
	output logic vga_reset,
	output draw_pkg::channel_t vga_r,
	output draw_pkg::channel_t vga_g,
	output draw_pkg::channel_t vga_b,
	input draw_pkg::coord_t vga_x,
	input draw_pkg::coord_t vga_y,
	input logic vga_request,
	output draw_pkg::sprite_addr_t ds_b_addr,
	input logic [15:0] ds_b_data_out,
	output logic ds_b_en
);
	import draw_pkg::*;

	logic first_frame;
	bcd4_t snap_perfect;
	bcd4_t snap_great;
	bcd4_t snap_good;
	bcd4_t snap_bad;
	bcd4_t snap_miss;
	bcd4_t snap_combo;
	grade_t snap_grade;

	frame_sequencer sequencer (
		.CLK(CLK),
		.RESET_L(RESET_L),
		.sig_on(sig_on),
		.perfect(perfect),
		.great(great),
		.good(good),
		.bad(bad),
		.miss(miss),
		.combo(combo),
		.current_score(current_score),
		.sig_done(sig_done),
		.vga_reset(vga_reset),
		.first_frame(first_frame),
		.snap_perfect(snap_perfect),
		.snap_great(snap_great),
		.snap_good(snap_good),
		.snap_bad(snap_bad),
		.snap_miss(snap_miss),
		.snap_combo(snap_combo),
		.snap_grade(snap_grade)
	);

	sprite_address_unit addresser (
		.vga_x(vga_x),
		.vga_y(vga_y),
		.is_key_down(is_key_down),
		.snap_perfect(snap_perfect),
		.snap_great(snap_great),
		.snap_good(snap_good),
		.snap_bad(snap_bad),
		.snap_miss(snap_miss),
		.snap_combo(snap_combo),
		.snap_grade(snap_grade),
		.ds_b_addr(ds_b_addr)
	);

	pixel_fetch fetch (
		.CLK(CLK),
		.RESET_L(RESET_L),
		.vga_request(vga_request),
		.first_frame(first_frame),
		.ds_b_data_out(ds_b_data_out),
		.ds_b_en(ds_b_en),
		.vga_r(vga_r),
		.vga_g(vga_g),
		.vga_b(vga_b)
	);

endmodule

//--- rtl/draw_pkg.sv
/*
 * Types shared by the score panel draw path.
 * grade_t is 4 bits wide so unused codes 6..15 pass through unchanged.
 */
package draw_pkg;

	typedef logic [9:0] coord_t; // vga x or y
	typedef logic [14:0] sprite_addr_t;

	// four BCD digits, msd drawn at the top
	typedef logic [15:0] bcd4_t;

	typedef logic [3:0] channel_t;

	typedef enum logic [3:0] {
		grade_none = 4'd0,
		grade_perfect = 4'd1,
		grade_great = 4'd2,
		grade_good = 4'd3,
		grade_bad = 4'd4,
		grade_miss = 4'd5
	} grade_t;

	// red in the low nibble
	typedef struct packed {
		channel_t b;
		channel_t g;
		channel_t r;
	} rgb_t;

endpackage

//--- rtl/frame_sequencer.sv
/*
 * Frame control of the score panel.
 * sig_on is a one-cycle strobe. sig_done follows it one cycle later.
 * The first sig_on starts the display, the second ends first-frame blanking.
 */
`timescale 1ns/1ps

module frame_sequencer (
	input logic CLK,
	input logic RESET_L,
	input logic sig_on,
	input draw_pkg::bcd4_t perfect,
	input draw_pkg::bcd4_t great,
	input draw_pkg::bcd4_t good,
	input draw_pkg::bcd4_t bad,
	input draw_pkg::bcd4_t miss,
	input draw_pkg::bcd4_t combo,
	input draw_pkg::grade_t current_score,
	output logic sig_done,
	output logic vga_reset,
	output logic first_frame,
	output draw_pkg::bcd4_t snap_perfect,
	output draw_pkg::bcd4_t snap_great,
	output draw_pkg::bcd4_t snap_good,
	output draw_pkg::bcd4_t snap_bad,
	output draw_pkg::bcd4_t snap_miss,
	output draw_pkg::bcd4_t snap_combo,
	output draw_pkg::grade_t snap_grade
);
	import draw_pkg::*;

	logic working;

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			working <= 1'b0;
			first_frame <= 1'b1;
			sig_done <= 1'b0;
			snap_perfect <= '0;
			snap_great <= '0;
			snap_good <= '0;
			snap_bad <= '0;
			snap_miss <= '0;
			snap_combo <= '0;
			snap_grade <= grade_none;
		end else begin
			sig_done <= sig_on; // nothing else to wait for
			if (sig_on) begin
				if (working)
					first_frame <= 1'b0;
				working <= 1'b1;
				snap_perfect <= perfect;
				snap_great <= great;
				snap_good <= good;
				snap_bad <= bad;
				snap_miss <= miss;
				snap_combo <= combo;
				snap_grade <= current_score;
			end
		end
	end

	assign vga_reset = !working;

endmodule

//--- rtl/lane_button_mapper.sv
/*
 * Lane rows and key indicator sprites.
 * The note area (x below 420) is part of the row but reads address 0.
 * Addresses wrap at 15 bits near the right edge of the screen.
 */
`timescale 1ns/1ps
`include "draw_cfg.svh"

module lane_button_mapper (
	input draw_pkg::coord_t vga_x,
	input draw_pkg::coord_t vga_y,
	input logic [3:0] is_key_down,
	output logic lane_hit,
	output draw_pkg::sprite_addr_t lane_addr
);
	import draw_pkg::*;

	always_comb begin : lane_search
		coord_t top;
		sprite_addr_t base;
		lane_hit = 1'b0;
		lane_addr = '0;
		for (int i = 0; i < `DRAW_LANE_CNT; i++) begin
			top = coord_t'(`DRAW_LANE_TOP + i * `DRAW_LANE_H);
			base = is_key_down[i] ? `DRAW_DOWN_BASE : `DRAW_UP_BASE;
			if (vga_y >= top && vga_y < top + `DRAW_LANE_H) begin
				lane_hit = 1'b1;
				if (vga_x >= `DRAW_BUTTON_X) begin
					// button sprite is 60 tall, column-major
					lane_addr = base
						+ sprite_addr_t'(vga_x - `DRAW_BUTTON_X) * `DRAW_LANE_H
						+ sprite_addr_t'(vga_y - top);
				end
			end
		end
	end

endmodule

//--- rtl/pixel_fetch.sv
/*
 * Pixel request to colour. The ROM enable stays high for three cycles and
 * the colour is latched on the third edge after the request.
 * No back-pressure: requests must be at least four cycles apart, and the
 * address must stay steady until the colour is latched.
 */
`timescale 1ns/1ps

module pixel_fetch (
	input logic CLK,
	input logic RESET_L,
	input logic vga_request,
	input logic first_frame,
	input logic [15:0] ds_b_data_out,
	output logic ds_b_en,
	output draw_pkg::channel_t vga_r,
	output draw_pkg::channel_t vga_g,
	output draw_pkg::channel_t vga_b
);
	import draw_pkg::*;

	logic [1:0] phase; // 0 idle, 1..3 fetching
	rgb_t pixel;

	assign pixel = rgb_t'(ds_b_data_out[11:0]);

	always_ff @(posedge CLK) begin
		if (!RESET_L) begin
			phase <= 2'd0;
			ds_b_en <= 1'b0;
			vga_r <= '0;
			vga_g <= '0;
			vga_b <= '0;
		end else if (vga_request && first_frame) begin
			vga_r <= '0; // black until the second frame
			vga_g <= '0;
			vga_b <= '0;
		end else if (vga_request) begin
			phase <= 2'd1; // restarts a running fetch
			ds_b_en <= 1'b1;
		end else if (phase != 2'd0) begin
			if (phase == 2'd3) begin
				vga_r <= pixel.r;
				vga_g <= pixel.g;
				vga_b <= pixel.b;
				ds_b_en <= 1'b0;
				phase <= 2'd0;
			end else begin
				phase <= phase + 2'd1;
			end
		end
	end

endmodule

//--- rtl/sign_mapper.sv
/*
 * Grade sign sprites: the five fixed signs and the current-grade box.
 * The box is a hit for every grade, but only grades 1..5 give a sprite.
 */
`timescale 1ns/1ps
`include "draw_cfg.svh"

module sign_mapper (
	input draw_pkg::coord_t vga_x,
	input draw_pkg::coord_t vga_y,
	input draw_pkg::grade_t snap_grade,
	output logic sign_hit,
	output draw_pkg::sprite_addr_t sign_addr
);
	import draw_pkg::*;

	localparam int sign_cnt = 5;
	localparam coord_t sign_x [sign_cnt] = '{`DRAW_PERFECT_X, `DRAW_GREAT_X,
		`DRAW_GOOD_X, `DRAW_BAD_X, `DRAW_MISS_X};
	localparam sprite_addr_t sign_base [sign_cnt] = '{`DRAW_PERFECT_BASE,
		`DRAW_GREAT_BASE, `DRAW_GOOD_BASE, `DRAW_BAD_BASE, `DRAW_MISS_BASE};

	sprite_addr_t grade_base;
	logic grade_valid;
	logic in_grade_box;

	always_comb begin
		grade_valid = 1'b1;
		case (snap_grade)
			grade_perfect: grade_base = sign_base[0];
			grade_great: grade_base = sign_base[1];
			grade_good: grade_base = sign_base[2];
			grade_bad: grade_base = sign_base[3];
			grade_miss: grade_base = sign_base[4];
			default: begin
				grade_base = '0;
				grade_valid = 1'b0;
			end
		endcase
	end

	assign in_grade_box = vga_x >= `DRAW_GRADE_X && vga_x < `DRAW_GRADE_X + `DRAW_SIGN_W
		&& vga_y >= `DRAW_GRADE_Y && vga_y < `DRAW_GRADE_Y + `DRAW_SIGN_H;

	always_comb begin
		sign_hit = 1'b0;
		sign_addr = '0;
		for (int i = 0; i < sign_cnt; i++) begin
			if (vga_x >= sign_x[i] && vga_x < sign_x[i] + `DRAW_SIGN_W
				&& vga_y >= `DRAW_SIGN_Y && vga_y < `DRAW_SIGN_Y + `DRAW_SIGN_H) begin
				sign_hit = 1'b1;
				sign_addr = sign_base[i] + sprite_addr_t'(vga_x - sign_x[i]) * `DRAW_SIGN_H
					+ sprite_addr_t'(vga_y - `DRAW_SIGN_Y);
			end
		end
		if (!sign_hit && in_grade_box) begin
			sign_hit = 1'b1;
			if (grade_valid)
				sign_addr = grade_base + sprite_addr_t'(vga_x - `DRAW_GRADE_X) * `DRAW_SIGN_H
					+ sprite_addr_t'(vga_y - `DRAW_GRADE_Y);
		end
	end

endmodule

//--- rtl/sprite_address_unit.sv
/*
 * Sprite ROM address for the current VGA pixel, purely combinational.
 * Priority is lane rows, then signs, then digits. Empty space reads address 0.
 */
`timescale 1ns/1ps

module sprite_address_unit (
	input draw_pkg::coord_t vga_x,
	input draw_pkg::coord_t vga_y,
	input logic [3:0] is_key_down,
	input draw_pkg::bcd4_t snap_perfect,
	input draw_pkg::bcd4_t snap_great,
	input draw_pkg::bcd4_t snap_good,
	input draw_pkg::bcd4_t snap_bad,
	input draw_pkg::bcd4_t snap_miss,
	input draw_pkg::bcd4_t snap_combo,
	input draw_pkg::grade_t snap_grade,
	output draw_pkg::sprite_addr_t ds_b_addr
);
	import draw_pkg::*;

	logic lane_hit;
	logic sign_hit;
	logic digit_hit;
	sprite_addr_t lane_addr;
	sprite_addr_t sign_addr;
	sprite_addr_t digit_addr;

	lane_button_mapper lanes (
		.vga_x(vga_x),
		.vga_y(vga_y),
		.is_key_down(is_key_down),
		.lane_hit(lane_hit),
		.lane_addr(lane_addr)
	);

	sign_mapper signs (
		.vga_x(vga_x),
		.vga_y(vga_y),
		.snap_grade(snap_grade),
		.sign_hit(sign_hit),
		.sign_addr(sign_addr)
	);

	digit_mapper digits (
		.vga_x(vga_x),
		.vga_y(vga_y),
		.snap_perfect(snap_perfect),
		.snap_great(snap_great),
		.snap_good(snap_good),
		.snap_bad(snap_bad),
		.snap_miss(snap_miss),
		.snap_combo(snap_combo),
		.digit_hit(digit_hit),
		.digit_addr(digit_addr)
	);

	always_comb begin
		if (lane_hit)
			ds_b_addr = lane_addr;
		else if (sign_hit)
			ds_b_addr = sign_addr;
		else if (digit_hit)
			ds_b_addr = digit_addr;
		else
			ds_b_addr = '0;
	end

endmodule

//--- run_sim.sh
#!/bin/sh
# builds the score panel testbench with Verilator and runs it
cd "$(dirname "$0")" &&
verilator --binary --timing -f sources.f --top-module draw_controller_tb -o draw_sim &&
./obj_dir/draw_sim || { echo "simulation failed"; exit 1; }

//--- sources.f
+incdir+include
rtl/draw_pkg.sv
rtl/frame_sequencer.sv
rtl/lane_button_mapper.sv
rtl/sign_mapper.sv
rtl/digit_mapper.sv
rtl/sprite_address_unit.sv
rtl/pixel_fetch.sv
rtl/draw_controller.sv
bench/draw_controller_tb.sv
